/* host_domain.sv */
`timescale 1ns/1ns
`default_nettype none

module host_domain (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  soc_pkg::lite_req_t                  cfg_req_i,
  output soc_pkg::lite_resp_t                 cfg_resp_o,
  input  soc_pkg::llc_evt_t                   llc_evt_i,
  output logic [soc_pkg::PmuNumCounter-1:0]  pmu_intr_o
);

  soc_pkg::lite_req_t  llc_cfg_req;
  soc_pkg::lite_resp_t llc_cfg_resp;
  soc_pkg::lite_req_t  pmu_cfg_req;
  soc_pkg::lite_resp_t pmu_cfg_resp;

  lite_cfg_demux u_demux (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .host_req_i  ( cfg_req_i    ),
    .host_resp_o ( cfg_resp_o   ),
    .llc_req_o   ( llc_cfg_req  ),
    .llc_resp_i  ( llc_cfg_resp ),
    .pmu_req_o   ( pmu_cfg_req  ),
    .pmu_resp_i  ( pmu_cfg_resp )
  );

  // Stands in for the cache configuration port
  llc_cfg_stub u_llc_stub (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .req_i   ( llc_cfg_req  ),
    .resp_o  ( llc_cfg_resp )
  );

  pmu_counters u_pmu (
    .clk_i     ( clk_i        ),
    .reset_i   ( reset_i      ),
    .req_i     ( pmu_cfg_req  ),
    .resp_o    ( pmu_cfg_resp ),
    .llc_evt_i ( llc_evt_i    ),
    .intr_o    ( pmu_intr_o   )
  );

endmodule

`default_nettype wire

/* lite_cfg_demux.sv */
`timescale 1ns/1ns
`default_nettype none

module lite_cfg_demux (
  input  logic               clk_i,
  input  logic               reset_i,
  input  soc_pkg::lite_req_t  host_req_i,
  output soc_pkg::lite_resp_t host_resp_o,
  output soc_pkg::lite_req_t  llc_req_o,
  input  soc_pkg::lite_resp_t llc_resp_i,
  output soc_pkg::lite_req_t  pmu_req_o,
  input  soc_pkg::lite_resp_t pmu_resp_i
);

  logic wr_to_pmu;
  logic rd_to_pmu;
  logic wr_busy;
  logic rd_busy;
  logic wr_fire;
  logic rd_fire;
  // Owner of the outstanding response, set means PMU
  logic wr_sel_q;
  logic rd_sel_q;

  assign wr_to_pmu = host_req_i.wr_addr[soc_pkg::TargetSelBit];
  assign rd_to_pmu = host_req_i.ar_addr[soc_pkg::TargetSelBit];

  // A response from either target blocks a new request on that channel
  assign wr_busy = llc_resp_i.b_valid | pmu_resp_i.b_valid;
  assign rd_busy = llc_resp_i.r_valid | pmu_resp_i.r_valid;

  assign wr_fire = host_req_i.wr_valid & host_resp_o.wr_ready;
  assign rd_fire = host_req_i.ar_valid & host_resp_o.ar_ready;

  always_comb begin
    llc_req_o = host_req_i;
    pmu_req_o = host_req_i;
    llc_req_o.wr_valid = host_req_i.wr_valid & ~wr_to_pmu & ~wr_busy;
    pmu_req_o.wr_valid = host_req_i.wr_valid & wr_to_pmu & ~wr_busy;
    llc_req_o.ar_valid = host_req_i.ar_valid & ~rd_to_pmu & ~rd_busy;
    pmu_req_o.ar_valid = host_req_i.ar_valid & rd_to_pmu & ~rd_busy;
    llc_req_o.b_ready = host_req_i.b_ready & ~wr_sel_q;
    pmu_req_o.b_ready = host_req_i.b_ready & wr_sel_q;
    llc_req_o.r_ready = host_req_i.r_ready & ~rd_sel_q;
    pmu_req_o.r_ready = host_req_i.r_ready & rd_sel_q;
  end

  always_comb begin
    host_resp_o.wr_ready = ~wr_busy & (wr_to_pmu ? pmu_resp_i.wr_ready : llc_resp_i.wr_ready);
    host_resp_o.ar_ready = ~rd_busy & (rd_to_pmu ? pmu_resp_i.ar_ready : llc_resp_i.ar_ready);
    if (wr_sel_q) begin
      host_resp_o.b_valid = pmu_resp_i.b_valid;
      host_resp_o.b_resp = pmu_resp_i.b_resp;
    end else begin
      host_resp_o.b_valid = llc_resp_i.b_valid;
      host_resp_o.b_resp = llc_resp_i.b_resp;
    end
    if (rd_sel_q) begin
      host_resp_o.r_valid = pmu_resp_i.r_valid;
      host_resp_o.r_data = pmu_resp_i.r_data;
      host_resp_o.r_resp = pmu_resp_i.r_resp;
    end else begin
      host_resp_o.r_valid = llc_resp_i.r_valid;
      host_resp_o.r_data = llc_resp_i.r_data;
      host_resp_o.r_resp = llc_resp_i.r_resp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_sel_q <= 1'b0;
      rd_sel_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_sel_q <= wr_to_pmu;
      end
      if (rd_fire) begin
        rd_sel_q <= rd_to_pmu;
      end
    end
  end

endmodule

`default_nettype wire

/* llc_cfg_stub.sv */
`timescale 1ns/1ns
`default_nettype none

module llc_cfg_stub (
  input  logic               clk_i,
  input  logic               reset_i,
  input  soc_pkg::lite_req_t  req_i,
  output soc_pkg::lite_resp_t resp_o
);

  logic b_pend_q;
  logic r_pend_q;

  // Ready drops while the response of that channel waits
  assign resp_o.wr_ready = ~b_pend_q;
  assign resp_o.ar_ready = ~r_pend_q;

  assign resp_o.b_valid = b_pend_q;
  assign resp_o.b_resp = soc_pkg::RespOkay;

  // Write data goes nowhere and every read sees the same word
  assign resp_o.r_valid = r_pend_q;
  assign resp_o.r_data = soc_pkg::StubReadData;
  assign resp_o.r_resp = soc_pkg::RespOkay;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      // Set on accept, cleared once the master takes the response
      if (b_pend_q) begin
        b_pend_q <= ~req_i.b_ready;
      end else begin
        b_pend_q <= req_i.wr_valid;
      end
      if (r_pend_q) begin
        r_pend_q <= ~req_i.r_ready;
      end else begin
        r_pend_q <= req_i.ar_valid;
      end
    end
  end

endmodule

`default_nettype wire

/* pmu_counters.sv */
`timescale 1ns/1ns
`default_nettype none

module pmu_counters (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  soc_pkg::lite_req_t                  req_i,
  output soc_pkg::lite_resp_t                 resp_o,
  input  soc_pkg::llc_evt_t                   llc_evt_i,
  output logic [soc_pkg::PmuNumCounter-1:0]  intr_o
);

  logic [soc_pkg::LiteDw-1:0] cnt_q [soc_pkg::PmuNumCounter];
  logic [soc_pkg::LiteDw-1:0] thr_q [soc_pkg::PmuNumCounter];
  soc_pkg::evt_sel_t evt_sel_q [soc_pkg::PmuNumCounter];

  soc_pkg::pmu_addr_t wr_addr;
  soc_pkg::pmu_addr_t rd_addr;
  logic [soc_pkg::LlcNumEvt-1:0] evt_vec;
  logic [soc_pkg::PmuNumCounter-1:0] cnt_we;
  logic [soc_pkg::PmuNumCounter-1:0] sel_we;
  logic [soc_pkg::PmuNumCounter-1:0] thr_we;
  logic wr_fire;
  logic rd_fire;
  logic b_pend_q;
  logic r_pend_q;
  logic [soc_pkg::LiteDw-1:0] rd_data;
  logic [soc_pkg::LiteDw-1:0] r_data_q;

  assign wr_addr = soc_pkg::pmu_addr_t'(req_i.wr_addr[soc_pkg::PmuDecodeW-1:0]);
  assign rd_addr = soc_pkg::pmu_addr_t'(req_i.ar_addr[soc_pkg::PmuDecodeW-1:0]);

  // Event index 0 is read_hit
  assign evt_vec = {llc_evt_i.write_miss, llc_evt_i.write_hit,
                    llc_evt_i.read_miss, llc_evt_i.read_hit};

  assign wr_fire = req_i.wr_valid & ~b_pend_q;
  assign rd_fire = req_i.ar_valid & ~r_pend_q;

  // Register write enables, unmapped offsets match nothing
  always_comb begin
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      cnt_we[i] = wr_fire && (wr_addr.grp == soc_pkg::pmu_grp_t'(i)) &&
                  (wr_addr.off == soc_pkg::PmuOffCount);
      sel_we[i] = wr_fire && (wr_addr.grp == soc_pkg::pmu_grp_t'(i)) &&
                  (wr_addr.off == soc_pkg::PmuOffEvtSel);
      thr_we[i] = wr_fire && (wr_addr.grp == soc_pkg::pmu_grp_t'(i)) &&
                  (wr_addr.off == soc_pkg::PmuOffThresh);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
        cnt_q[i] <= '0;
        thr_q[i] <= '0;
        evt_sel_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
        // A host write beats a same-cycle event
        if (cnt_we[i]) begin
          cnt_q[i] <= req_i.wr_data;
        end else if (evt_vec[evt_sel_q[i]]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
        if (sel_we[i]) begin
          evt_sel_q[i] <= req_i.wr_data[$bits(soc_pkg::evt_sel_t)-1:0];
        end
        if (thr_we[i]) begin
          thr_q[i] <= req_i.wr_data;
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      if (rd_addr.grp == soc_pkg::pmu_grp_t'(i)) begin
        case (rd_addr.off)
          soc_pkg::PmuOffCount: rd_data = cnt_q[i];
          soc_pkg::PmuOffEvtSel: rd_data[$bits(soc_pkg::evt_sel_t)-1:0] = evt_sel_q[i];
          soc_pkg::PmuOffThresh: rd_data = thr_q[i];
          default: rd_data = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (b_pend_q) begin
        b_pend_q <= ~req_i.b_ready;
      end else begin
        b_pend_q <= req_i.wr_valid;
      end
      if (r_pend_q) begin
        r_pend_q <= ~req_i.r_ready;
      end else begin
        r_pend_q <= req_i.ar_valid;
      end
    end
  end

  // Read data is captured at accept and held until taken
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= rd_data;
    end
  end

  assign resp_o.wr_ready = ~b_pend_q;
  assign resp_o.b_valid = b_pend_q;
  assign resp_o.b_resp = soc_pkg::RespOkay;
  assign resp_o.ar_ready = ~r_pend_q;
  assign resp_o.r_valid = r_pend_q;
  assign resp_o.r_data = r_data_q;
  assign resp_o.r_resp = soc_pkg::RespOkay;

  // A zero threshold disables the interrupt
  always_comb begin
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      intr_o[i] = (thr_q[i] != '0) && (cnt_q[i] >= thr_q[i]);
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_host_domain -f src.f -o sim_host_domain \
  > build.log 2>&1 &&
./obj_dir/sim_host_domain > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // Host configuration bus
  localparam int unsigned LiteAw = 32;
  localparam int unsigned LiteDw = 32;

  // Address bit that picks the target, clear for the cache, set for the PMU
  localparam int unsigned TargetSelBit = 12;

  localparam logic [1:0] RespOkay = 2'b00;

  // Read value of the cache configuration stand-in
  localparam logic [LiteDw-1:0] StubReadData = 32'hDEADF000;

  // PMU register map
  localparam int unsigned PmuNumCounter = 4;
  localparam int unsigned PmuRegStride = 32'h10;
  localparam int unsigned PmuDecodeW = 12;
  localparam int unsigned PmuOffW = $clog2(PmuRegStride);
  localparam int unsigned PmuGrpW = PmuDecodeW - PmuOffW;

  typedef logic [PmuOffW-1:0] pmu_off_t;
  typedef logic [PmuGrpW-1:0] pmu_grp_t;

  localparam pmu_off_t PmuOffCount = pmu_off_t'(4'h0);
  localparam pmu_off_t PmuOffEvtSel = pmu_off_t'(4'h4);
  localparam pmu_off_t PmuOffThresh = pmu_off_t'(4'h8);

  // Low bits of a PMU address, split into counter group and register offset
  typedef struct packed {
    pmu_grp_t grp;
    pmu_off_t off;
  } pmu_addr_t;

  // Cache event strobes
  localparam int unsigned LlcNumEvt = 4;

  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_evt_t;

  // Select 0 is read_hit, 3 is write_miss
  typedef logic [$clog2(LlcNumEvt)-1:0] evt_sel_t;

  // Master to target
  typedef struct packed {
    logic              wr_valid;
    logic [LiteAw-1:0] wr_addr;
    logic [LiteDw-1:0] wr_data;
    logic              b_ready;
    logic              ar_valid;
    logic [LiteAw-1:0] ar_addr;
    logic              r_ready;
  } lite_req_t;

  // Target to master
  typedef struct packed {
    logic              wr_ready;
    logic              b_valid;
    logic [1:0]        b_resp;
    logic              ar_ready;
    logic              r_valid;
    logic [LiteDw-1:0] r_data;
    logic [1:0]        r_resp;
  } lite_resp_t;

endpackage

`default_nettype wire

/* src.f */
soc_pkg.sv
lite_cfg_demux.sv
llc_cfg_stub.sv
pmu_counters.sv
host_domain.sv
tb_host_domain.sv

/* tb_host_domain.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_host_domain;

  typedef logic [soc_pkg::LiteAw-1:0] addr_t;
  typedef logic [soc_pkg::LiteDw-1:0] word_t;
  typedef logic [soc_pkg::PmuNumCounter-1:0] intr_vec_t;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned BusTimeout = 16;
  // Cycle budget per test, reset first
  localparam int unsigned TestCycles = 8 + 70 + 20 + 100 + 260 + 60 + 30;
  localparam int unsigned WatchdogNs = (TestCycles + 200) * ClkPeriod;
  localparam int IntrCtr = 2;
  localparam soc_pkg::evt_sel_t IntrEvt = 2'd3;

  logic clk_i;
  logic reset_i;
  soc_pkg::lite_req_t cfg_req;
  soc_pkg::lite_resp_t cfg_resp;
  soc_pkg::llc_evt_t llc_evt;
  intr_vec_t pmu_intr;
  int unsigned errors;
  logic [31:0] lfsr_state;

  host_domain u_dut (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .cfg_req_i  ( cfg_req  ),
    .cfg_resp_o ( cfg_resp ),
    .llc_evt_i  ( llc_evt  ),
    .pmu_intr_o ( pmu_intr )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
    $display("CHECKS FAILED");
    $finish;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Bit k of v is the event with select index k
  function automatic soc_pkg::llc_evt_t to_evt(input logic [soc_pkg::LlcNumEvt-1:0] v);
    soc_pkg::llc_evt_t e;
    e.read_hit = v[0];
    e.read_miss = v[1];
    e.write_hit = v[2];
    e.write_miss = v[3];
    return e;
  endfunction

  function automatic addr_t pmu_reg(input int idx, input int off);
    return addr_t'((1 << soc_pkg::TargetSelBit) + idx * soc_pkg::PmuRegStride + off);
  endfunction

  task automatic check_data(input string name, input word_t exp_v, input word_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp_v, input logic [1:0] act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_intr(input string name, input intr_vec_t exp_v, input intr_vec_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic lite_write(input addr_t addr, input word_t data);
    int unsigned waited;
    waited = 0;
    @(posedge clk_i);
    cfg_req.wr_valid <= 1'b1;
    cfg_req.wr_addr <= addr;
    cfg_req.wr_data <= data;
    cfg_req.b_ready <= 1'b1;
    @(negedge clk_i);
    while (!cfg_resp.wr_ready && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    cfg_req.wr_valid <= 1'b0;
    @(negedge clk_i);
    while (!cfg_resp.b_valid && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    if (waited >= BusTimeout) begin
      errors++;
      $display("Write to %h got no response within %0d cycles", addr, BusTimeout);
    end else begin
      check_resp("b_resp", soc_pkg::RespOkay, cfg_resp.b_resp);
      // No new write is taken while this response waits
      check_flag("wr_ready", 1'b0, cfg_resp.wr_ready);
    end
    @(posedge clk_i);
    cfg_req.b_ready <= 1'b0;
  endtask

  task automatic lite_read(input addr_t addr, output word_t data);
    int unsigned waited;
    waited = 0;
    data = '0;
    @(posedge clk_i);
    cfg_req.ar_valid <= 1'b1;
    cfg_req.ar_addr <= addr;
    cfg_req.r_ready <= 1'b1;
    @(negedge clk_i);
    while (!cfg_resp.ar_ready && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    cfg_req.ar_valid <= 1'b0;
    @(negedge clk_i);
    while (!cfg_resp.r_valid && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    if (waited >= BusTimeout) begin
      errors++;
      $display("Read from %h got no response within %0d cycles", addr, BusTimeout);
    end else begin
      data = cfg_resp.r_data;
      check_resp("r_resp", soc_pkg::RespOkay, cfg_resp.r_resp);
    end
    @(posedge clk_i);
    cfg_req.r_ready <= 1'b0;
  endtask

  // One cycle high, one cycle low
  task automatic pulse_event(input soc_pkg::evt_sel_t idx);
    logic [soc_pkg::LlcNumEvt-1:0] ev;
    ev = '0;
    ev[idx] = 1'b1;
    @(posedge clk_i);
    llc_evt <= to_evt(ev);
    @(posedge clk_i);
    llc_evt <= '0;
  endtask

  task automatic test_reset_state();
    word_t data;
    @(negedge clk_i);
    check_flag("b_valid", 1'b0, cfg_resp.b_valid);
    check_flag("r_valid", 1'b0, cfg_resp.r_valid);
    check_intr("pmu_intr_o", '0, pmu_intr);
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      for (int off = 0; off < 16; off += 4) begin
        lite_read(pmu_reg(i, off), data);
        check_data($sformatf("r_data pmu[%0d]+%0d", i, off), '0, data);
      end
    end
  endtask

  task automatic test_cache_stub();
    word_t data;
    lite_read(addr_t'(32'h0000_0000), data);
    check_data("r_data llc", 32'hDEAD_F000, data);
    lite_read(addr_t'(32'h0000_0FFC), data);
    check_data("r_data llc", 32'hDEAD_F000, data);
    lite_read(addr_t'(32'hFFFF_E000), data);
    check_data("r_data llc", 32'hDEAD_F000, data);
    lite_write(addr_t'(32'h0000_0100), 32'h1234_5678);
  endtask

  task automatic test_pmu_regs();
    word_t sel_val;
    word_t thr_val;
    word_t cnt_val;
    word_t data;
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      sel_val = 32'hA5A5_5A5C + word_t'(i);
      thr_val = 32'h1000_0000 + word_t'(i * 32'h111);
      cnt_val = 32'hCAFE_0000 + word_t'(i);
      lite_write(pmu_reg(i, 4), sel_val);
      lite_write(pmu_reg(i, 8), thr_val);
      lite_write(pmu_reg(i, 0), cnt_val);
      lite_read(pmu_reg(i, 4), data);
      check_data($sformatf("evt_sel[%0d]", i), sel_val & 32'h3, data);
      lite_read(pmu_reg(i, 8), data);
      check_data($sformatf("threshold[%0d]", i), thr_val, data);
      lite_read(pmu_reg(i, 0), data);
      check_data($sformatf("counter[%0d]", i), cnt_val, data);
    end
  endtask

  task automatic test_counting();
    soc_pkg::evt_sel_t sel [soc_pkg::PmuNumCounter];
    int unsigned tally [soc_pkg::PmuNumCounter];
    logic [soc_pkg::LlcNumEvt-1:0] ev;
    word_t data;
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      sel[i] = soc_pkg::evt_sel_t'((i + 1) % soc_pkg::LlcNumEvt);
      tally[i] = 0;
      lite_write(pmu_reg(i, 4), word_t'(sel[i]));
      lite_write(pmu_reg(i, 0), '0);
    end
    ev = '0;
    repeat (200) begin
      @(posedge clk_i);
      repeat (soc_pkg::LlcNumEvt) begin
        lfsr_state = lfsr_step(lfsr_state);
        ev = {lfsr_state[0], ev[soc_pkg::LlcNumEvt-1:1]};
      end
      llc_evt <= to_evt(ev);
      for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
        if (ev[sel[i]]) tally[i]++;
      end
    end
    @(posedge clk_i);
    llc_evt <= '0;
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      lite_read(pmu_reg(i, 0), data);
      check_data($sformatf("counter[%0d]", i), word_t'(tally[i]), data);
    end
  endtask

  task automatic test_interrupt();
    for (int i = 0; i < soc_pkg::PmuNumCounter; i++) begin
      lite_write(pmu_reg(i, 8), '0);
    end
    lite_write(pmu_reg(IntrCtr, 4), word_t'(IntrEvt));
    lite_write(pmu_reg(IntrCtr, 0), '0);
    lite_write(pmu_reg(IntrCtr, 8), 32'd5);
    repeat (4) pulse_event(IntrEvt);
    @(negedge clk_i);
    check_intr("pmu_intr_o", '0, pmu_intr);
    pulse_event(IntrEvt);
    @(negedge clk_i);
    check_intr("pmu_intr_o", intr_vec_t'(1 << IntrCtr), pmu_intr);
    lite_write(pmu_reg(IntrCtr, 0), '0);
    @(negedge clk_i);
    check_intr("pmu_intr_o", '0, pmu_intr);
  endtask

  task automatic test_back_pressure();
    word_t held;
    int unsigned waited;
    waited = 0;
    // Counter 1 counts write_hit
    lite_write(pmu_reg(1, 4), 32'd2);
    lite_write(pmu_reg(1, 0), 32'h0BAD_CAFE);
    @(posedge clk_i);
    cfg_req.ar_valid <= 1'b1;
    cfg_req.ar_addr <= pmu_reg(1, 0);
    cfg_req.r_ready <= 1'b0;
    @(negedge clk_i);
    while (!cfg_resp.ar_ready && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    cfg_req.ar_valid <= 1'b0;
    // The counter moves on while its read response waits
    llc_evt <= to_evt(4'b0100);
    @(negedge clk_i);
    while (!cfg_resp.r_valid && waited < BusTimeout) begin
      waited++;
      @(negedge clk_i);
    end
    if (waited >= BusTimeout) begin
      errors++;
      $display("Held read got no response within %0d cycles", BusTimeout);
    end
    held = cfg_resp.r_data;
    check_data("r_data", 32'h0BAD_CAFE, held);
    repeat (6) begin
      @(negedge clk_i);
      check_flag("r_valid", 1'b1, cfg_resp.r_valid);
      check_data("r_data", held, cfg_resp.r_data);
      check_flag("ar_ready", 1'b0, cfg_resp.ar_ready);
    end
    @(posedge clk_i);
    cfg_req.r_ready <= 1'b1;
    // Response is taken at this edge
    @(posedge clk_i);
    cfg_req.r_ready <= 1'b0;
    llc_evt <= '0;
    @(negedge clk_i);
    check_flag("r_valid", 1'b0, cfg_resp.r_valid);
  endtask

  initial begin
    errors = 0;
    lfsr_state = 32'hc886;
    reset_i = 1'b1;
    cfg_req = '0;
    llc_evt = '0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset_state();
    test_cache_stub();
    test_pmu_regs();
    test_counting();
    test_interrupt();
    test_back_pressure();
    $display("Tests done with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
